//--- Bender.yml
package:
  name: dino_runner

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dino_pkg.sv
      - hw/uart_rx.sv
      - hw/uart_cmd_decoder.sv
      - hw/jumper_motion.sv
      - hw/obstacle_track.sv
      - hw/game_referee.sv
      - hw/score_display.sv
      - hw/dino_runner_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_dino_runner.sv

//--- compile.f
+incdir+hw
hw/dino_pkg.sv
hw/uart_rx.sv
hw/uart_cmd_decoder.sv
hw/jumper_motion.sv
hw/obstacle_track.sv
hw/game_referee.sv
hw/score_display.sv
hw/dino_runner_top.sv
tests/tb_dino_runner.sv

//--- hw/dino_config.svh
`ifndef DINO_CONFIG_SVH
`define DINO_CONFIG_SVH

// System clock and serial line
`define DINO_CLK_HZ       100_000_000
`define DINO_BAUD         115200

// Clock cycles per motion step
`define DINO_STEP_DIV     64

// Screen and object geometry in pixels
`define DINO_X_SCREEN     640
`define DINO_OBJ_SIZE     16

// Fixed player column and the ground row shared by both objects
`define DINO_PLAYER_X     104
`define DINO_GROUND_Y     269

// Rows climbed at the top of a jump
`define DINO_JUMP_HEIGHT  80

// ASCII 'J' starts a jump
`define DINO_CMD_JUMP     8'h4A

// Score saturates at three decimal digits
`define DINO_SCORE_MAX    999

`endif

//--- hw/dino_pkg.sv
`default_nettype none

package dino_pkg;

    // Field widths
    localparam int X_POS_W = 10;
    localparam int Y_POS_W = 9;
    localparam int SCORE_W = 10;
    localparam int SEG_W   = 7;

    // Screen column and row
    typedef logic [X_POS_W-1:0] x_pos_t;
    typedef logic [Y_POS_W-1:0] y_pos_t;

    // Up to 999 passes
    typedef logic [SCORE_W-1:0] score_t;

    typedef logic [3:0] bcd_digit_t;

    // Active low, segment a in bit 0
    typedef logic [SEG_W-1:0] seg_t;

    typedef enum logic [1:0] {
        JUMP_RUNNING    = 2'd0,
        JUMP_ASCENDING  = 2'd1,
        JUMP_DESCENDING = 2'd2
    } jump_phase_t;

endpackage

`default_nettype wire

//--- hw/dino_runner_top.sv
`timescale 1ns/1ps
`default_nettype none

module dino_runner_top (
    input  wire              Clock,
    input  wire              rst_n,
    input  wire              rx_line,
    input  wire              jump_key,
    input  wire              restart_key,
    output dino_pkg::seg_t   hex0,
    output dino_pkg::seg_t   hex1,
    output dino_pkg::seg_t   hex2,
    output dino_pkg::seg_t   hex3,
    output dino_pkg::seg_t   hex4,
    output dino_pkg::seg_t   hex5,
    output logic             game_over,
    output dino_pkg::y_pos_t player_y,
    output dino_pkg::x_pos_t obstacle_x
);

    logic             byte_valid;
    logic [7:0]       byte_data;
    logic             jump_cmd;
    logic             step;
    logic             restart;
    dino_pkg::score_t score;
    dino_pkg::score_t high_score;

    uart_rx u_rx (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .rx_line    (rx_line),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    uart_cmd_decoder u_dec (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .jump_cmd   (jump_cmd)
    );

    jumper_motion u_jumper (
        .Clock       (Clock),
        .rst_n       (rst_n),
        .jump_key    (jump_key),
        .restart_key (restart_key),
        .jump_cmd    (jump_cmd),
        .game_over   (game_over),
        .step        (step),
        .restart     (restart),
        .player_y    (player_y)
    );

    obstacle_track u_obstacle (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .step       (step),
        .game_over  (game_over),
        .restart    (restart),
        .obstacle_x (obstacle_x)
    );

    game_referee u_referee (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .restart    (restart),
        .player_y   (player_y),
        .obstacle_x (obstacle_x),
        .game_over  (game_over),
        .score      (score),
        .high_score (high_score)
    );

    // Only the display path is combinational
    score_display u_display (
        .score      (score),
        .high_score (high_score),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .hex4       (hex4),
        .hex5       (hex5)
    );

endmodule

`default_nettype wire

//--- hw/game_referee.sv
`timescale 1ns/1ps
`default_nettype none

`include "dino_config.svh"

module game_referee (
    input  wire              Clock,
    input  wire              rst_n,
    input  wire              restart,
    input  wire              dino_pkg::y_pos_t player_y,
    input  wire              dino_pkg::x_pos_t obstacle_x,
    output logic             game_over,
    output dino_pkg::score_t score,
    output dino_pkg::score_t high_score
);

    localparam dino_pkg::x_pos_t PLAYER_X = dino_pkg::x_pos_t'(`DINO_PLAYER_X);
    localparam dino_pkg::x_pos_t X_START =
        dino_pkg::x_pos_t'(`DINO_X_SCREEN - `DINO_OBJ_SIZE);
    localparam dino_pkg::score_t SCORE_MAX = dino_pkg::score_t'(`DINO_SCORE_MAX);

    // One extra bit so the box edges cannot wrap
    localparam logic [10:0] OBJ_W        = 11'(`DINO_OBJ_SIZE);
    localparam logic [10:0] PLAYER_LEFT  = 11'(`DINO_PLAYER_X);
    localparam logic [10:0] PLAYER_RIGHT = 11'(`DINO_PLAYER_X + `DINO_OBJ_SIZE);
    localparam logic [9:0]  GROUND_ROW   = 10'(`DINO_GROUND_Y);

    logic [10:0]      obs_left;
    logic [9:0]       player_bottom;
    logic             overlap_x;
    logic             collision;
    logic             crossing;
    logic             pass_now;
    dino_pkg::x_pos_t prev_x;
    logic             prev_collision;
    logic             passed;
    logic             pass_hit;
    logic             game_over_d;

    assign obs_left      = {1'b0, obstacle_x};
    assign player_bottom = {1'b0, player_y} + 10'(`DINO_OBJ_SIZE);
    assign overlap_x     = (obs_left < PLAYER_RIGHT) && (obs_left + OBJ_W > PLAYER_LEFT);
    assign collision     = overlap_x && (player_bottom > GROUND_ROW);

    // Obstacle steps past the player column
    assign crossing = (prev_x > PLAYER_X) && (obstacle_x <= PLAYER_X);
    assign pass_now = crossing && !passed && !collision && !prev_collision && !game_over;

    always_ff @(posedge Clock) begin
        if (!rst_n || restart) begin
            game_over <= 1'b0;
        end else if (collision) begin
            game_over <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rst_n || restart) begin
            prev_x         <= X_START;
            prev_collision <= 1'b0;
            passed         <= 1'b0;
            pass_hit       <= 1'b0;
        end else begin
            prev_x         <= obstacle_x;
            prev_collision <= collision;
            pass_hit       <= pass_now;
            // Column jumps up only when the obstacle wraps
            if (obstacle_x > prev_x) begin
                passed <= 1'b0;
            end else if (crossing) begin
                passed <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!rst_n || restart) begin
            score <= '0;
        end else if (pass_hit && score < SCORE_MAX) begin
            score <= score + 1'b1;
        end
    end

    // High score survives restart
    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            game_over_d <= 1'b0;
            high_score  <= '0;
        end else begin
            game_over_d <= game_over;
            if (game_over && !game_over_d && score > high_score) begin
                high_score <= score;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/jumper_motion.sv
`timescale 1ns/1ps
`default_nettype none

`include "dino_config.svh"

module jumper_motion (
    input  wire              Clock,
    input  wire              rst_n,
    input  wire              jump_key,
    input  wire              restart_key,
    input  wire              jump_cmd,
    input  wire              game_over,
    output logic             step,
    output logic             restart,
    output dino_pkg::y_pos_t player_y
);

    localparam int STEP_W = $clog2(`DINO_STEP_DIV);
    localparam dino_pkg::y_pos_t GROUND = dino_pkg::y_pos_t'(`DINO_GROUND_Y);
    localparam dino_pkg::y_pos_t TOP =
        dino_pkg::y_pos_t'(`DINO_GROUND_Y - `DINO_JUMP_HEIGHT);

    // Bit 0 is jump, bit 1 is restart, both stored as pressed high
    logic [1:0]            key_meta;
    logic [1:0]            key_sync;
    logic [STEP_W-1:0]     step_cnt;
    logic                  jump_req;
    dino_pkg::jump_phase_t phase;

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            key_meta <= 2'b00;
            key_sync <= 2'b00;
        end else begin
            key_meta <= {~restart_key, ~jump_key};
            key_sync <= key_meta;
        end
    end

    assign restart = key_sync[1];

    // Step divider stops while the game is over
    always_ff @(posedge Clock) begin
        if (!rst_n || restart) begin
            step_cnt <= '0;
            step     <= 1'b0;
        end else if (game_over) begin
            step <= 1'b0;
        end else if (step_cnt == STEP_W'(`DINO_STEP_DIV - 1)) begin
            step_cnt <= '0;
            step     <= 1'b1;
        end else begin
            step_cnt <= step_cnt + 1'b1;
            step     <= 1'b0;
        end
    end

    // Held until the next step takes it
    always_ff @(posedge Clock) begin
        if (!rst_n || restart) begin
            jump_req <= 1'b0;
        end else if (phase != dino_pkg::JUMP_RUNNING) begin
            jump_req <= 1'b0;
        end else if (!game_over && (key_sync[0] || jump_cmd)) begin
            jump_req <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rst_n || restart) begin
            phase    <= dino_pkg::JUMP_RUNNING;
            player_y <= GROUND;
        end else if (step) begin
            case (phase)
                dino_pkg::JUMP_RUNNING: begin
                    if (jump_req) begin
                        phase    <= dino_pkg::JUMP_ASCENDING;
                        player_y <= player_y - 1'b1;
                    end
                end
                dino_pkg::JUMP_ASCENDING: begin
                    player_y <= player_y - 1'b1;
                    if (player_y == TOP + 1'b1) begin
                        phase <= dino_pkg::JUMP_DESCENDING;
                    end
                end
                dino_pkg::JUMP_DESCENDING: begin
                    player_y <= player_y + 1'b1;
                    if (player_y == GROUND - 1'b1) begin
                        phase <= dino_pkg::JUMP_RUNNING;
                    end
                end
                default: begin
                    phase <= dino_pkg::JUMP_RUNNING;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/obstacle_track.sv
`timescale 1ns/1ps
`default_nettype none

`include "dino_config.svh"

module obstacle_track (
    input  wire              Clock,
    input  wire              rst_n,
    input  wire              step,
    input  wire              game_over,
    input  wire              restart,
    output dino_pkg::x_pos_t obstacle_x
);

    // Spawn column at the right edge
    localparam dino_pkg::x_pos_t X_START =
        dino_pkg::x_pos_t'(`DINO_X_SCREEN - `DINO_OBJ_SIZE);

    logic advance;
    logic at_left_edge;

    assign advance      = step && !game_over;
    assign at_left_edge = (obstacle_x <= dino_pkg::x_pos_t'(1));

    always_ff @(posedge Clock) begin
        if (!rst_n || restart) begin
            obstacle_x <= X_START;
        end else if (advance) begin
            if (at_left_edge) begin
                obstacle_x <= X_START;
            end else begin
                obstacle_x <= obstacle_x - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/score_display.sv
`timescale 1ns/1ps
`default_nettype none

module score_display (
    input  wire             dino_pkg::score_t score,
    input  wire             dino_pkg::score_t high_score,
    output dino_pkg::seg_t  hex0,
    output dino_pkg::seg_t  hex1,
    output dino_pkg::seg_t  hex2,
    output dino_pkg::seg_t  hex3,
    output dino_pkg::seg_t  hex4,
    output dino_pkg::seg_t  hex5
);

    logic [11:0] score_bcd;
    logic [11:0] high_bcd;

    // Double dabble into three BCD digits
    function automatic logic [11:0] to_bcd(input dino_pkg::score_t bin);
        logic [11:0] bcd;
        bcd = '0;
        for (int i = $bits(bin) - 1; i >= 0; i--) begin
            if (bcd[3:0] >= 4'd5) bcd[3:0] = bcd[3:0] + 4'd3;
            if (bcd[7:4] >= 4'd5) bcd[7:4] = bcd[7:4] + 4'd3;
            if (bcd[11:8] >= 4'd5) bcd[11:8] = bcd[11:8] + 4'd3;
            bcd = {bcd[10:0], bin[i]};
        end
        return bcd;
    endfunction

    function automatic dino_pkg::seg_t to_seg(input dino_pkg::bcd_digit_t digit);
        case (digit)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111; // blank
        endcase
    endfunction

    assign score_bcd = to_bcd(score);
    assign high_bcd  = to_bcd(high_score);

    // Current score on the right three digits
    assign hex0 = to_seg(score_bcd[3:0]);
    assign hex1 = to_seg(score_bcd[7:4]);
    assign hex2 = to_seg(score_bcd[11:8]);
    assign hex3 = to_seg(high_bcd[3:0]);
    assign hex4 = to_seg(high_bcd[7:4]);
    assign hex5 = to_seg(high_bcd[11:8]);

endmodule

`default_nettype wire

//--- hw/uart_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "dino_config.svh"

module uart_cmd_decoder (
    input  wire        Clock,
    input  wire        rst_n,
    input  wire        byte_valid,
    input  wire  [7:0] byte_data,
    output logic       jump_cmd
);

    logic is_jump;

    // Any other byte is dropped silently
    assign is_jump = byte_valid && (byte_data == `DINO_CMD_JUMP);

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            jump_cmd <= 1'b0;
        end else begin
            jump_cmd <= is_jump;
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "dino_config.svh"

module uart_rx (
    input  wire        Clock,
    input  wire        rst_n,
    input  wire        rx_line,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    // Clock cycles per 16x oversampling tick
    localparam int TICK_DIV = `DINO_CLK_HZ / (`DINO_BAUD * 16);
    localparam int TICK_W   = $clog2(TICK_DIV);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [TICK_W-1:0] tick_cnt;
    logic              tick_16x;
    logic              rx_meta;
    logic              rx_sync;
    logic [1:0]        state;
    logic [3:0]        os_cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        shift_reg;
    logic              sample_now;

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            tick_16x <= 1'b0;
        end else if (tick_cnt == TICK_W'(TICK_DIV - 1)) begin
            tick_cnt <= '0;
            tick_16x <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            tick_16x <= 1'b0;
        end
    end

    // Line idles high
    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    assign sample_now = tick_16x && (os_cnt == 4'd0);

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            os_cnt     <= 4'd0;
            bit_idx    <= 3'd0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (tick_16x) begin
                case (state)
                    ST_IDLE: begin
                        // Half a bit to reach the start bit centre
                        if (!rx_sync) begin
                            state  <= ST_START;
                            os_cnt <= 4'd7;
                        end
                    end
                    ST_START: begin
                        if (os_cnt != 4'd0) begin
                            os_cnt <= os_cnt - 1'b1;
                        end else if (!rx_sync) begin
                            state   <= ST_DATA;
                            os_cnt  <= 4'd15;
                            bit_idx <= 3'd0;
                        end else begin
                            // Glitch, not a real start bit
                            state <= ST_IDLE;
                        end
                    end
                    ST_DATA: begin
                        if (os_cnt != 4'd0) begin
                            os_cnt <= os_cnt - 1'b1;
                        end else begin
                            os_cnt <= 4'd15;
                            if (bit_idx == 3'd7) begin
                                state <= ST_STOP;
                            end else begin
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end
                    end
                    default: begin
                        if (os_cnt != 4'd0) begin
                            os_cnt <= os_cnt - 1'b1;
                        end else begin
                            byte_valid <= 1'b1;
                            state      <= ST_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge Clock) begin
        if (sample_now && state == ST_DATA) begin
            shift_reg[bit_idx] <= rx_sync;
        end
        if (sample_now && state == ST_STOP) begin
            byte_data <= shift_reg;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_dino_runner.sv
`timescale 1ns/1ps
`default_nettype none

`include "dino_config.svh"

module tb_dino_runner;

    localparam int BIT_CYCLES     = `DINO_CLK_HZ / `DINO_BAUD;
    localparam int STEP           = `DINO_STEP_DIV;
    localparam int OBJ            = `DINO_OBJ_SIZE;
    localparam int PLAYER_X       = `DINO_PLAYER_X;
    localparam int GROUND_Y       = `DINO_GROUND_Y;
    localparam int TOP_Y          = `DINO_GROUND_Y - `DINO_JUMP_HEIGHT;
    localparam int X_START        = `DINO_X_SCREEN - `DINO_OBJ_SIZE;
    localparam int TIMEOUT_CYCLES = 400000;

    logic             Clock;
    logic             rst_n;
    logic             rx_line;
    logic             jump_key;
    logic             restart_key;
    dino_pkg::seg_t   hex0;
    dino_pkg::seg_t   hex1;
    dino_pkg::seg_t   hex2;
    dino_pkg::seg_t   hex3;
    dino_pkg::seg_t   hex4;
    dino_pkg::seg_t   hex5;
    logic             game_over;
    dino_pkg::y_pos_t player_y;
    dino_pkg::x_pos_t obstacle_x;

    int   checks;
    int   errors;
    int   cycle_count;
    int   lowest_y;
    int   prev_y;
    int   prev_x;
    bit   prev_over;
    bit   prev_overlap;
    bit   alive_window;
    int   score_before;
    logic [7:0] rand_byte;

    dino_runner_top UUT (
        .Clock       (Clock),
        .rst_n       (rst_n),
        .rx_line     (rx_line),
        .jump_key    (jump_key),
        .restart_key (restart_key),
        .hex0        (hex0),
        .hex1        (hex1),
        .hex2        (hex2),
        .hex3        (hex3),
        .hex4        (hex4),
        .hex5        (hex5),
        .game_over   (game_over),
        .player_y    (player_y),
        .obstacle_x  (obstacle_x)
    );

    always #5 Clock = ~Clock;

    always @(posedge Clock) begin
        cycle_count <= cycle_count + 1;
    end

    // Active-low patterns, segment a in bit 0
    function automatic int seg_to_digit(input dino_pkg::seg_t seg);
        case (seg)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            default:    return -1;
        endcase
    endfunction

    function automatic int display_value(input dino_pkg::seg_t hundreds,
                                         input dino_pkg::seg_t tens,
                                         input dino_pkg::seg_t ones);
        int d2;
        int d1;
        int d0;
        d2 = seg_to_digit(hundreds);
        d1 = seg_to_digit(tens);
        d0 = seg_to_digit(ones);
        if (d2 < 0 || d1 < 0 || d0 < 0) begin
            return -1;
        end
        return d2 * 100 + d1 * 10 + d0;
    endfunction

    // Box rule for a collision
    function automatic bit boxes_overlap(input int y, input int x);
        return (x < PLAYER_X + OBJ) && (x + OBJ > PLAYER_X) && (y + OBJ > GROUND_Y);
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // 8-N-1 frame, LSB first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge Clock);
            rx_line <= frame[i];
            repeat (BIT_CYCLES - 1) @(posedge Clock);
        end
    endtask

    task automatic expect_takeoff(input int max_cycles);
        int waited;
        waited = 0;
        while (player_y == GROUND_Y && waited < max_cycles) begin
            @(negedge Clock);
            waited++;
        end
        checks++;
        assert (player_y != GROUND_Y) else begin
            errors++;
            $display("Player did not leave the ground within %0d cycles of the stop bit",
                     max_cycles);
        end
    endtask

    task automatic press_jump();
        @(posedge Clock);
        jump_key <= 1'b0;
        repeat (4) @(posedge Clock);
        jump_key <= 1'b1;
    endtask

    task automatic press_restart();
        @(posedge Clock);
        restart_key <= 1'b0;
        repeat (4) @(posedge Clock);
        restart_key <= 1'b1;
    endtask

    task automatic wait_obstacle(input int column);
        while (obstacle_x != column) @(negedge Clock);
    endtask

    // Invariants checked on every cycle
    always @(negedge Clock) begin
        if (rst_n) begin
            if (player_y < lowest_y) begin
                lowest_y = player_y;
            end
            assert (player_y >= TOP_Y && player_y <= GROUND_Y) else begin
                errors++;
                $display("** Error: player_y is 0x%0h, outside 0x%0h to 0x%0h",
                         player_y, TOP_Y, GROUND_Y);
            end
            assert (player_y <= prev_y + 1 && player_y + 1 >= prev_y) else begin
                errors++;
                $display("** Error: player_y moved from 0x%0h to 0x%0h", prev_y, player_y);
            end
            if (!prev_over) begin
                assert (game_over == prev_overlap) else begin
                    errors++;
                    $display("** Error: game_over is 0x%0h, expected 0x%0h",
                             game_over, prev_overlap);
                end
            end
            if (prev_over && game_over) begin
                assert (obstacle_x == prev_x) else begin
                    errors++;
                    $display("** Error: obstacle_x is 0x%0h while frozen at 0x%0h",
                             obstacle_x, prev_x);
                end
            end
            if (alive_window) begin
                assert (!game_over) else begin
                    errors++;
                    $display("** Error: game_over is 0x1 during a timed jump, expected 0x0");
                end
            end
        end
        prev_y       = player_y;
        prev_x       = obstacle_x;
        prev_over    = game_over;
        prev_overlap = boxes_overlap(player_y, obstacle_x);
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) @(posedge Clock);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Value checks: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h235c));
        Clock        = 1'b0;
        checks       = 0;
        errors       = 0;
        cycle_count  = 0;
        lowest_y     = GROUND_Y;
        alive_window = 0;
        rst_n       <= 1'b0;
        rx_line     <= 1'b1;
        jump_key    <= 1'b1;
        restart_key <= 1'b1;
        repeat (10) @(posedge Clock);
        rst_n <= 1'b1;
        @(negedge Clock);

        // Reset state
        check_value("game_over", game_over, 0);
        check_value("player_y", player_y, GROUND_Y);
        check_value("obstacle_x", obstacle_x, X_START);
        check_value("score display", display_value(hex2, hex1, hex0), 0);
        check_value("high score display", display_value(hex5, hex4, hex3), 0);

        // Serial jump while the obstacle is far away
        lowest_y = GROUND_Y;
        fork
            send_byte(`DINO_CMD_JUMP);
            begin
                repeat (9 * BIT_CYCLES + BIT_CYCLES / 2) @(posedge Clock);
                expect_takeoff(2 * STEP);
            end
        join
        while (player_y != GROUND_Y) @(negedge Clock);
        check_value("lowest player_y", lowest_y, TOP_Y);

        rand_byte = 8'($urandom);
        while (rand_byte == `DINO_CMD_JUMP) begin
            rand_byte = 8'($urandom);
        end
        lowest_y = GROUND_Y;
        send_byte(rand_byte);
        repeat (3 * STEP) @(negedge Clock);
        check_value("lowest player_y", lowest_y, GROUND_Y);

        // Two timed jumps over the obstacle
        for (int pass = 1; pass <= 2; pass++) begin
            wait_obstacle(PLAYER_X + 60);
            alive_window = 1;
            press_jump();
            wait_obstacle(PLAYER_X);
            repeat (4) @(negedge Clock);
            alive_window = 0;
            check_value("score display", display_value(hex2, hex1, hex0), pass);
        end

        // No jump, so the obstacle runs into the player
        score_before = 2;
        while (!game_over) @(negedge Clock);
        check_value("obstacle_x", obstacle_x, PLAYER_X + OBJ - 1);
        repeat (3 * STEP) @(negedge Clock);
        check_value("obstacle_x", obstacle_x, PLAYER_X + OBJ - 1);
        check_value("high score display", display_value(hex5, hex4, hex3), score_before);

        // Restart keeps the high score
        press_restart();
        repeat (4) @(negedge Clock);
        check_value("game_over", game_over, 0);
        check_value("obstacle_x", obstacle_x, X_START);
        check_value("score display", display_value(hex2, hex1, hex0), 0);
        check_value("high score display", display_value(hex5, hex4, hex3), score_before);

        // A shorter game, one pass and then a crash
        wait_obstacle(PLAYER_X + 60);
        alive_window = 1;
        press_jump();
        wait_obstacle(PLAYER_X);
        repeat (4) @(negedge Clock);
        alive_window = 0;
        check_value("score display", display_value(hex2, hex1, hex0), 1);
        while (!game_over) @(negedge Clock);
        repeat (4) @(negedge Clock);
        check_value("score display", display_value(hex2, hex1, hex0), 1);
        check_value("high score display", display_value(hex5, hex4, hex3), score_before);

        $display("Value checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
